/* filelist.f */
+incdir+hw
hw/m6502_isa_pkg.sv
hw/m6502_bus_pkg.sv
hw/m6502_decode.sv
hw/m6502_execute.sv
hw/m6502_alu.sv
hw/m6502_cpu.sv
verification/m6502_cpu_assert.sv
verification/tb_m6502.sv

/* hw/m6502_alu.sv */
`timescale 1ns/100ps

module m6502_alu (
   input  logic                     clk,
   input  logic                     reset_n,
   input  logic                     alu_start,
   input  m6502_isa_pkg::alu_func_t alu_func,
   input  m6502_bus_pkg::byte_t     in_a,
   input  m6502_bus_pkg::byte_t     in_b,
   output logic                     flag_n,
   output logic                     flag_z,
   output logic                     flag_c
);

   logic [8:0] diff;

   assign diff = {1'b0, in_a} - {1'b0, in_b};   // bit 8 is the borrow.

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         flag_n <= 1'b0;
         flag_z <= 1'b0;
         flag_c <= 1'b0;
      end
      else if (alu_start)
         case (alu_func)
            m6502_isa_pkg::ALU_CMP:
            begin
               flag_n <= diff[7];
               flag_z <= (in_a == in_b);
               flag_c <= !diff[8];                  // no borrow means a >= b.
            end
            m6502_isa_pkg::ALU_PASS:
            begin
               flag_n <= in_a[7];
               flag_z <= (in_a == 8'h00);
            end
            default: ;
         endcase
   end

endmodule

/* hw/m6502_bus_pkg.sv */
`include "m6502_consts.svh"

package m6502_bus_pkg;

   typedef logic [`M6502_ADDR_W-1:0] addr_t;
   typedef logic [`M6502_DATA_W-1:0] byte_t;

   // states of the opcode fetch sequencer in the top level.
   typedef enum logic [2:0]
   {
      ST_RESET,
      ST_VECTOR,
      ST_FETCH,
      ST_DECODE,
      ST_EXECUTE
   } fetch_state_t;

endpackage

/* hw/m6502_consts.svh */
`ifndef M6502_CONSTS_SVH
`define M6502_CONSTS_SVH

//////////////////////////////////////////////////
// bus widths

`define M6502_DATA_W 8                   // one byte per transfer.
`define M6502_ADDR_W 16                  // 64 KB address space.

//////////////////////////////////////////////////
// vectors

// address of the reset vector's low byte.
`define M6502_RESET_VECTOR 16'hfffc

`endif

/* hw/m6502_cpu.sv */
`timescale 1ns/100ps
`include "m6502_consts.svh"

module m6502_cpu (
   input  logic                 clk,
   input  logic                 reset_n,
   output m6502_bus_pkg::addr_t addr,
   input  m6502_bus_pkg::byte_t rd_data,
   output m6502_bus_pkg::byte_t wr_data,
   output logic                 wr_en,
   output logic                 rd_req,
   input  logic                 ready
);

   m6502_bus_pkg::fetch_state_t fetch_state;
   m6502_bus_pkg::addr_t        pc;
   m6502_bus_pkg::addr_t        seq_addr;
   m6502_bus_pkg::byte_t        reg_a;
   m6502_bus_pkg::byte_t        reg_x;
   m6502_bus_pkg::byte_t        reg_y;
   m6502_bus_pkg::byte_t        opcode;
   logic                        vec_hi;
   logic                        decode_start;
   logic                        exec_start;
   logic                        in_execute;

   m6502_isa_pkg::cpu_op_t      op;
   m6502_isa_pkg::addr_mode_t   mode;
   m6502_isa_pkg::alu_func_t    dec_alu_func;
   logic                        op_valid;

   m6502_bus_pkg::addr_t        ex_addr;
   logic                        ex_rd_req;
   logic                        ex_wr_en;
   m6502_bus_pkg::byte_t        ex_wr_data;
   logic                        alu_start;
   m6502_isa_pkg::alu_func_t    alu_func;
   m6502_bus_pkg::byte_t        alu_in_a;
   m6502_bus_pkg::byte_t        alu_in_b;
   m6502_bus_pkg::byte_t        load_value;
   logic                        exec_done;
   m6502_bus_pkg::addr_t        pc_next;
   logic                        flag_z;

   //////////////////////////////////////////////////
   // fetch sequencer

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         fetch_state  <= m6502_bus_pkg::ST_RESET;
         pc           <= '0;
         reg_a        <= '0;
         reg_x        <= '0;
         reg_y        <= '0;
         vec_hi       <= 1'b0;
         decode_start <= 1'b0;
         exec_start   <= 1'b0;
      end
      else
      begin
         decode_start <= 1'b0;
         exec_start   <= 1'b0;
         case (fetch_state)
            m6502_bus_pkg::ST_RESET:
               fetch_state <= m6502_bus_pkg::ST_VECTOR;
            m6502_bus_pkg::ST_VECTOR:
               if (ready)
               begin
                  vec_hi <= !vec_hi;
                  if (vec_hi)
                  begin
                     pc          <= {rd_data, pc[7:0]};
                     fetch_state <= m6502_bus_pkg::ST_FETCH;
                  end
                  else
                     pc <= {pc[15:8], rd_data};
               end
            m6502_bus_pkg::ST_FETCH:
               if (ready)
               begin
                  opcode       <= rd_data;
                  pc           <= pc + 16'd1;
                  decode_start <= 1'b1;
                  fetch_state  <= m6502_bus_pkg::ST_DECODE;
               end
            m6502_bus_pkg::ST_DECODE:
            begin
               exec_start  <= 1'b1;              // decode outputs are valid from here on.
               fetch_state <= m6502_bus_pkg::ST_EXECUTE;
            end
            default:
               if (exec_done)
               begin
                  pc          <= pc_next;
                  fetch_state <= m6502_bus_pkg::ST_FETCH;
                  if (op_valid && dec_alu_func == m6502_isa_pkg::ALU_PASS)
                     case (op)
                        m6502_isa_pkg::OP_LOAD_A: reg_a <= load_value;
                        m6502_isa_pkg::OP_LOAD_X: reg_x <= load_value;
                        m6502_isa_pkg::OP_LOAD_Y: reg_y <= load_value;
                        default: ;
                     endcase
               end
         endcase
      end
   end

   // execute owns the port for the whole execute state.
   assign in_execute = (fetch_state == m6502_bus_pkg::ST_EXECUTE);
   assign seq_addr   = (fetch_state == m6502_bus_pkg::ST_VECTOR) ?
                       `M6502_RESET_VECTOR + m6502_bus_pkg::addr_t'(vec_hi) : pc;
   assign addr       = in_execute ? ex_addr : seq_addr;
   assign rd_req     = in_execute ? ex_rd_req : (fetch_state == m6502_bus_pkg::ST_VECTOR ||
                                                 fetch_state == m6502_bus_pkg::ST_FETCH);
   assign wr_en      = in_execute && ex_wr_en;
   assign wr_data    = ex_wr_data;

   m6502_decode u_decode (
      .clk          (clk),
      .reset_n      (reset_n),
      .decode_start (decode_start),
      .opcode       (opcode),
      .op           (op),
      .mode         (mode),
      .alu_func     (dec_alu_func),
      .op_valid     (op_valid)
   );

   m6502_execute u_execute (
      .clk         (clk),
      .reset_n     (reset_n),
      .exec_start  (exec_start),
      .op          (op),
      .mode        (mode),
      .pc          (pc),
      .reg_a       (reg_a),
      .reg_x       (reg_x),
      .reg_y       (reg_y),
      .flag_z      (flag_z),
      .bus_addr    (ex_addr),
      .bus_rd_req  (ex_rd_req),
      .bus_wr_en   (ex_wr_en),
      .bus_wr_data (ex_wr_data),
      .bus_rdata   (rd_data),
      .ready       (ready),
      .alu_start   (alu_start),
      .alu_func    (alu_func),
      .alu_in_a    (alu_in_a),
      .alu_in_b    (alu_in_b),
      .load_value  (load_value),
      .exec_done   (exec_done),
      .pc_next     (pc_next)
   );

   m6502_alu u_alu (
      .clk       (clk),
      .reset_n   (reset_n),
      .alu_start (alu_start),
      .alu_func  (alu_func),
      .in_a      (alu_in_a),
      .in_b      (alu_in_b),
      .flag_n    (),
      .flag_z    (flag_z),
      .flag_c    ()
   );

endmodule

/* hw/m6502_decode.sv */
`timescale 1ns/100ps

module m6502_decode (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      decode_start,
   input  m6502_bus_pkg::byte_t      opcode,
   output m6502_isa_pkg::cpu_op_t    op,
   output m6502_isa_pkg::addr_mode_t mode,
   output m6502_isa_pkg::alu_func_t  alu_func,
   output logic                      op_valid
);

   m6502_isa_pkg::cpu_op_t    nxt_op;
   m6502_isa_pkg::addr_mode_t nxt_mode;
   m6502_isa_pkg::addr_mode_t grp_mode;
   logic                      nxt_valid;

   always_comb
   begin
      case (opcode[4:2])                            // bbb field of aaabbbcc.
         3'd0:    grp_mode = m6502_isa_pkg::MODE_IND_X;
         3'd1:    grp_mode = m6502_isa_pkg::MODE_ZP;
         3'd2:    grp_mode = m6502_isa_pkg::MODE_IMM;
         3'd3:    grp_mode = m6502_isa_pkg::MODE_ABS;
         3'd4:    grp_mode = m6502_isa_pkg::MODE_IND_Y;
         3'd5:    grp_mode = m6502_isa_pkg::MODE_ZP_X;
         3'd6:    grp_mode = m6502_isa_pkg::MODE_ABS_Y;
         default: grp_mode = m6502_isa_pkg::MODE_ABS_X;
      endcase
   end

   always_comb
   begin
      nxt_op    = m6502_isa_pkg::OP_NOP;
      nxt_mode  = grp_mode;
      nxt_valid = 1'b1;
      casez (opcode)
         8'h89:      nxt_valid = 1'b0;              // no immediate store.
         8'b101???01: nxt_op = m6502_isa_pkg::OP_LOAD_A;
         8'b100???01: nxt_op = m6502_isa_pkg::OP_STORE_A;
         8'b110???01: nxt_op = m6502_isa_pkg::OP_COMPARE;
         8'ha2:
         begin
            nxt_op   = m6502_isa_pkg::OP_LOAD_X;
            nxt_mode = m6502_isa_pkg::MODE_IMM;
         end
         8'ha0:
         begin
            nxt_op   = m6502_isa_pkg::OP_LOAD_Y;
            nxt_mode = m6502_isa_pkg::MODE_IMM;
         end
         8'hf0:
         begin
            nxt_op   = m6502_isa_pkg::OP_BRANCH_EQ;
            nxt_mode = m6502_isa_pkg::MODE_REL;
         end
         8'hd0:
         begin
            nxt_op   = m6502_isa_pkg::OP_BRANCH_NE;
            nxt_mode = m6502_isa_pkg::MODE_REL;
         end
         default: nxt_valid = 1'b0;
      endcase
      if (!nxt_valid)
         nxt_mode = m6502_isa_pkg::MODE_NONE;      // unknown opcodes run as one-byte nops.
   end

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         op       <= m6502_isa_pkg::OP_NOP;
         mode     <= m6502_isa_pkg::MODE_NONE;
         alu_func <= m6502_isa_pkg::ALU_NONE;
         op_valid <= 1'b0;
      end
      else if (decode_start)
      begin
         op       <= nxt_op;
         mode     <= nxt_mode;
         alu_func <= m6502_isa_pkg::op_alu_func(nxt_op);
         op_valid <= nxt_valid;
      end
   end

endmodule

/* hw/m6502_execute.sv */
`timescale 1ns/100ps

module m6502_execute (
   input  logic                      clk,
   input  logic                      reset_n,
   input  logic                      exec_start,
   input  m6502_isa_pkg::cpu_op_t    op,
   input  m6502_isa_pkg::addr_mode_t mode,
   input  m6502_bus_pkg::addr_t      pc,
   input  m6502_bus_pkg::byte_t      reg_a,
   input  m6502_bus_pkg::byte_t      reg_x,
   input  m6502_bus_pkg::byte_t      reg_y,
   input  logic                      flag_z,
   output m6502_bus_pkg::addr_t      bus_addr,
   output logic                      bus_rd_req,
   output logic                      bus_wr_en,
   output m6502_bus_pkg::byte_t      bus_wr_data,
   input  m6502_bus_pkg::byte_t      bus_rdata,
   input  logic                      ready,
   output logic                      alu_start,
   output m6502_isa_pkg::alu_func_t  alu_func,
   output m6502_bus_pkg::byte_t      alu_in_a,
   output m6502_bus_pkg::byte_t      alu_in_b,
   output m6502_bus_pkg::byte_t      load_value,
   output logic                      exec_done,
   output m6502_bus_pkg::addr_t      pc_next
);

   typedef enum logic [2:0]
   {
      EX_IDLE,
      EX_OPERAND,
      EX_ADDR_HI,
      EX_PTR_LO,
      EX_PTR_HI,
      EX_ACCESS
   } exec_state_t;

   exec_state_t               state;
   m6502_isa_pkg::cpu_op_t    op_r;
   m6502_isa_pkg::addr_mode_t mode_r;
   m6502_bus_pkg::addr_t      pc_r;
   m6502_bus_pkg::byte_t      addr_lo;
   m6502_bus_pkg::byte_t      pre_idx;
   m6502_bus_pkg::byte_t      post_idx;
   m6502_bus_pkg::addr_t      pc_after;
   m6502_bus_pkg::addr_t      branch_target;
   logic [1:0]                oper_len;
   logic                      is_store;
   logic                      is_abs;
   logic                      is_last;
   logic                      taken;

   always_comb
   begin
      pre_idx  = 8'h00;
      post_idx = 8'h00;
      oper_len = 2'd1;
      case (mode_r)
         m6502_isa_pkg::MODE_ZP_X, m6502_isa_pkg::MODE_IND_X: pre_idx = reg_x;
         m6502_isa_pkg::MODE_IND_Y: post_idx = reg_y;
         m6502_isa_pkg::MODE_ABS:   oper_len = 2'd2;
         m6502_isa_pkg::MODE_ABS_X:
         begin
            post_idx = reg_x;
            oper_len = 2'd2;
         end
         m6502_isa_pkg::MODE_ABS_Y:
         begin
            post_idx = reg_y;
            oper_len = 2'd2;
         end
         default: ;
      endcase
   end

   assign is_store      = (op_r == m6502_isa_pkg::OP_STORE_A);
   assign is_abs        = (oper_len == 2'd2);
   assign bus_rd_req    = (state inside {EX_OPERAND, EX_ADDR_HI, EX_PTR_LO, EX_PTR_HI}) ||
                          (state == EX_ACCESS && !is_store);
   assign bus_wr_en     = (state == EX_ACCESS) && is_store;
   assign bus_wr_data   = reg_a;
   assign is_last       = ready && (state == EX_ACCESS || (state == EX_OPERAND &&
                          mode_r inside {m6502_isa_pkg::MODE_IMM, m6502_isa_pkg::MODE_REL}));
   assign pc_after      = pc_r + m6502_bus_pkg::addr_t'(oper_len);
   assign branch_target = pc_after + {{8{bus_rdata[7]}}, bus_rdata};   // signed offset.
   assign taken         = (op_r == m6502_isa_pkg::OP_BRANCH_EQ) ? flag_z : !flag_z;

   //////////////////////////////////////////////////
   // address sequencer

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         state     <= EX_IDLE;
         exec_done <= 1'b0;
         alu_start <= 1'b0;
      end
      else
      begin
         exec_done <= is_last || (exec_start && mode == m6502_isa_pkg::MODE_NONE);
         alu_start <= is_last && (m6502_isa_pkg::op_alu_func(op_r) != m6502_isa_pkg::ALU_NONE);
         case (state)
            EX_IDLE:
               if (exec_start && mode != m6502_isa_pkg::MODE_NONE)
                  state <= EX_OPERAND;
            EX_OPERAND:
               if (ready)
               begin
                  if (mode_r inside {m6502_isa_pkg::MODE_IMM, m6502_isa_pkg::MODE_REL})
                     state <= EX_IDLE;
                  else if (mode_r inside {m6502_isa_pkg::MODE_IND_X, m6502_isa_pkg::MODE_IND_Y})
                     state <= EX_PTR_LO;
                  else
                     state <= is_abs ? EX_ADDR_HI : EX_ACCESS;
               end
            EX_ADDR_HI, EX_PTR_HI:
               if (ready)
                  state <= EX_ACCESS;
            EX_PTR_LO:
               if (ready)
                  state <= EX_PTR_HI;
            default:
               if (ready)
                  state <= EX_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (exec_start)
      begin
         op_r     <= op;
         mode_r   <= mode;
         pc_r     <= pc;
         bus_addr <= pc;                                // operand byte comes first.
         pc_next  <= pc;
      end
      if (ready)
         case (state)
            EX_OPERAND:
            begin
               addr_lo  <= bus_rdata;
               bus_addr <= is_abs ? pc_r + 16'd1 : {8'h00, bus_rdata + pre_idx};
            end
            EX_ADDR_HI, EX_PTR_HI:
               bus_addr <= {bus_rdata, addr_lo} + m6502_bus_pkg::addr_t'(post_idx);
            EX_PTR_LO:
            begin
               addr_lo  <= bus_rdata;
               bus_addr <= {8'h00, bus_addr[7:0] + 8'h01};  // pointer high byte wraps in page 0.
            end
            default: ;
         endcase
      if (is_last)
      begin
         load_value <= bus_rdata;
         alu_func   <= m6502_isa_pkg::op_alu_func(op_r);
         alu_in_a   <= (op_r == m6502_isa_pkg::OP_COMPARE) ? reg_a : bus_rdata;
         alu_in_b   <= bus_rdata;
         pc_next    <= (mode_r == m6502_isa_pkg::MODE_REL && taken) ? branch_target : pc_after;
      end
   end

endmodule

/* hw/m6502_isa_pkg.sv */
package m6502_isa_pkg;

   typedef logic [2:0] cpu_op_t;
   typedef logic [3:0] addr_mode_t;
   typedef logic [1:0] alu_func_t;

   //////////////////////////////////////////////////
   // operations

   localparam cpu_op_t OP_NOP       = 3'd0;
   localparam cpu_op_t OP_LOAD_A    = 3'd1;
   localparam cpu_op_t OP_LOAD_X    = 3'd2;
   localparam cpu_op_t OP_LOAD_Y    = 3'd3;
   localparam cpu_op_t OP_STORE_A   = 3'd4;
   localparam cpu_op_t OP_COMPARE   = 3'd5;
   localparam cpu_op_t OP_BRANCH_EQ = 3'd6;
   localparam cpu_op_t OP_BRANCH_NE = 3'd7;

   //////////////////////////////////////////////////
   // addressing modes

   localparam addr_mode_t MODE_NONE  = 4'd0;
   localparam addr_mode_t MODE_IMM   = 4'd1;
   localparam addr_mode_t MODE_ZP    = 4'd2;
   localparam addr_mode_t MODE_ZP_X  = 4'd3;
   localparam addr_mode_t MODE_ABS   = 4'd4;
   localparam addr_mode_t MODE_ABS_X = 4'd5;
   localparam addr_mode_t MODE_ABS_Y = 4'd6;
   localparam addr_mode_t MODE_IND_X = 4'd7;
   localparam addr_mode_t MODE_IND_Y = 4'd8;
   localparam addr_mode_t MODE_REL   = 4'd9;

   localparam alu_func_t ALU_PASS = 2'd0;
   localparam alu_func_t ALU_CMP  = 2'd1;
   localparam alu_func_t ALU_NONE = 2'd2;

   // loads only pass the byte to the flags, compare subtracts.
   function automatic alu_func_t op_alu_func(input cpu_op_t op);
      alu_func_t func;
      case (op)
         OP_LOAD_A, OP_LOAD_X, OP_LOAD_Y: func = ALU_PASS;
         OP_COMPARE:                      func = ALU_CMP;
         default:                         func = ALU_NONE;
      endcase
      return func;
   endfunction

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# builds the m6502 testbench with Verilator, runs it into sim.log and checks the verdict.

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
   --top-module tb_m6502 -o tb_m6502 \
   && ./obj_dir/tb_m6502 +verilator+error+limit+1000 > sim.log 2>&1 \
   || { echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "test failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "test passed" sim.log || { echo "FAIL: no verdict found in sim.log"; exit 1; }
echo "PASS"

/* verification/m6502_cpu_assert.sv */
`timescale 1ns/100ps
`include "m6502_consts.svh"

module m6502_cpu_assert (
   input logic                        clk,
   input logic                        reset_n,
   input m6502_bus_pkg::addr_t        addr,
   input m6502_bus_pkg::byte_t        rd_data,
   input m6502_bus_pkg::byte_t        wr_data,
   input logic                        wr_en,
   input logic                        rd_req,
   input logic                        ready,
   input m6502_bus_pkg::fetch_state_t fetch_state
);

   int                   fail_count = 0;
   logic [1:0]           reads_done;           // counts accepted reads since reset and stops at 3.
   m6502_bus_pkg::addr_t vector;
   logic                 rd_accept;

   assign rd_accept = rd_req && ready;

   always_ff @(posedge clk)
   begin
      if (!reset_n)
      begin
         reads_done <= 2'd0;
         vector     <= '0;
      end
      else if (rd_accept && reads_done != 2'd3)
      begin
         reads_done <= reads_done + 2'd1;
         if (reads_done == 2'd0)
            vector[7:0] <= rd_data;                // low byte of the reset vector.
         if (reads_done == 2'd1)
            vector[15:8] <= rd_data;
      end
   end

   //////////////////////////////////////////////////
   // reset and vector fetch

   a_quiet_in_reset: assert property (@(posedge clk)
      !reset_n && $past(!reset_n) |-> !rd_req && !wr_en)
   else
   begin
      fail_count++;
      $error("memory request while reset_n is low");
   end

   a_first_request: assert property (@(posedge clk) $rose(reset_n) |=> rd_req)
   else
   begin
      fail_count++;
      $error("no read request on the cycle after reset release");
   end

   a_vector_low: assert property (@(posedge clk) disable iff (!reset_n)
      rd_accept && reads_done == 2'd0 |-> addr == `M6502_RESET_VECTOR)
   else
   begin
      fail_count++;
      $error("first read after reset is at %h", addr);
   end

   a_vector_high: assert property (@(posedge clk) disable iff (!reset_n)
      rd_accept && reads_done == 2'd1 |-> addr == `M6502_RESET_VECTOR + 16'd1)
   else
   begin
      fail_count++;
      $error("second read after reset is at %h", addr);
   end

   a_start_fetch: assert property (@(posedge clk) disable iff (!reset_n)
      rd_accept && reads_done == 2'd2 |->
      fetch_state == m6502_bus_pkg::ST_FETCH && addr == vector)
   else
   begin
      fail_count++;
      $error("first opcode fetch at %h in state %0d, vector is %h", addr, fetch_state, vector);
   end

   //////////////////////////////////////////////////
   // memory port protocol

   a_one_direction: assert property (@(posedge clk) disable iff (!reset_n)
      !(rd_req && wr_en))
   else
   begin
      fail_count++;
      $error("rd_req and wr_en high together");
   end

   a_hold_request: assert property (@(posedge clk) disable iff (!reset_n)
      (rd_req || wr_en) && !ready |=> $stable(addr) && $stable(rd_req) && $stable(wr_en))
   else
   begin
      fail_count++;
      $error("request or address changed while ready was low");
   end

   a_hold_data: assert property (@(posedge clk) disable iff (!reset_n)
      wr_en && !ready |=> $stable(wr_data))
   else
   begin
      fail_count++;
      $error("wr_data changed while ready was low");
   end

endmodule

/* verification/tb_m6502.sv */
`timescale 1ns/100ps
`include "m6502_consts.svh"

module tb_m6502;

   localparam int                   TIMEOUT_CYCLES = 4000;
   localparam int                   N_STORES       = 9;
   localparam m6502_bus_pkg::byte_t X_VAL          = 8'h03;
   localparam m6502_bus_pkg::byte_t Y_VAL          = 8'h05;
   localparam m6502_bus_pkg::byte_t IMM_DATA       = 8'h5a;
   localparam m6502_bus_pkg::addr_t IND_X_PTR      = 16'h0500;
   localparam m6502_bus_pkg::byte_t IND_X_DATA     = 8'hc3;
   localparam m6502_bus_pkg::addr_t IND_Y_BASE     = 16'h0600;
   localparam m6502_bus_pkg::byte_t IND_Y_DATA     = 8'h7e;
   localparam m6502_bus_pkg::addr_t SKIP_EQ        = 16'h0380;
   localparam m6502_bus_pkg::addr_t SKIP_NE        = 16'h0381;
   localparam m6502_bus_pkg::addr_t BEQ_OFFSET_AT  = 16'h0221;
   localparam m6502_bus_pkg::addr_t BNE_OFFSET_AT  = 16'h0228;
   localparam m6502_bus_pkg::addr_t DONE_ADDR      = 16'h0ff0;
   localparam m6502_bus_pkg::byte_t DONE_MARK      = 8'ha5;

   logic                 clk;
   logic                 reset_n;
   m6502_bus_pkg::addr_t addr;
   m6502_bus_pkg::byte_t rd_data;
   m6502_bus_pkg::byte_t wr_data;
   logic                 wr_en;
   logic                 rd_req;
   logic                 ready;

   m6502_bus_pkg::byte_t mem [0:65535];
   m6502_bus_pkg::byte_t program_bytes [0:50];
   m6502_bus_pkg::addr_t exp_addr [0:N_STORES-1];
   m6502_bus_pkg::byte_t exp_data [0:N_STORES-1];
   m6502_bus_pkg::addr_t target_addr;
   integer               seed;
   int                   waits_left;
   int                   store_idx;
   int                   errors;
   int                   cycles;
   logic                 in_access;
   logic                 target_due;
   logic                 done_seen;

   always #20 clk = ~clk;

   m6502_cpu u_m6502_cpu (
      .clk     (clk),
      .reset_n (reset_n),
      .addr    (addr),
      .rd_data (rd_data),
      .wr_data (wr_data),
      .wr_en   (wr_en),
      .rd_req  (rd_req),
      .ready   (ready)
   );

   bind m6502_cpu m6502_cpu_assert u_cpu_assert (
      .clk         (clk),
      .reset_n     (reset_n),
      .addr        (addr),
      .rd_data     (rd_data),
      .wr_data     (wr_data),
      .wr_en       (wr_en),
      .rd_req      (rd_req),
      .ready       (ready),
      .fetch_state (fetch_state)
   );

   //////////////////////////////////////////////////
   // program and expected stores

   task automatic load_memory();
      for (int i = 0; i < 65536; i++)
         mem[i] = i[15:8] ^ i[7:0];
      program_bytes = '{
         8'ha2, X_VAL,                    // ldx #.
         8'ha0, Y_VAL,                    // ldy #.
         8'ha9, IMM_DATA,                 // lda #.
         8'h85, 8'h40,                    // sta zp.
         8'h95, 8'hfe,                    // sta zp,x wraps to page 0.
         8'h8d, 8'h00, 8'h03,             // sta abs.
         8'h9d, 8'hff, 8'h03,             // sta abs,x carries into the high byte.
         8'h99, 8'h10, 8'h03,             // sta abs,y.
         8'ha1, 8'h20,                    // lda (zp,x).
         8'h8d, 8'h50, 8'h03,
         8'hb1, 8'h30,                    // lda (zp),y.
         8'h81, 8'h20,                    // sta (zp,x).
         8'h91, 8'h30,                    // sta (zp),y.
         8'hc9, IND_Y_DATA,               // equal compare.
         8'hf0, 8'h03,
         8'h8d, SKIP_EQ[7:0], SKIP_EQ[15:8],
         8'hc5, 8'h40,                    // unequal compare against the zp store.
         8'hd0, 8'h03,
         8'h8d, SKIP_NE[7:0], SKIP_NE[15:8],
         8'ha9, DONE_MARK,
         8'h8d, DONE_ADDR[7:0], DONE_ADDR[15:8],
         8'hd0, 8'hfe                     // spins on itself.
      };
      for (int i = 0; i < 51; i++)
         mem[16'h0200 + i] = program_bytes[i];
      mem[`M6502_RESET_VECTOR]         = 8'h00;
      mem[`M6502_RESET_VECTOR + 16'd1] = 8'h02;
      mem[{8'h00, 8'h20 + X_VAL}]         = IND_X_PTR[7:0];
      mem[{8'h00, 8'h21 + X_VAL}]         = IND_X_PTR[15:8];
      mem[16'h0030]                       = IND_Y_BASE[7:0];
      mem[16'h0031]                       = IND_Y_BASE[15:8];
      mem[IND_X_PTR]                      = IND_X_DATA;
      mem[IND_Y_BASE + {8'h00, Y_VAL}]    = IND_Y_DATA;
   endtask

   task automatic fill_expected();
      exp_addr[0] = 16'h0040;
      exp_addr[1] = {8'h00, 8'hfe + X_VAL};
      exp_addr[2] = 16'h0300;
      exp_addr[3] = 16'h03ff + {8'h00, X_VAL};
      exp_addr[4] = 16'h0310 + {8'h00, Y_VAL};
      for (int i = 0; i < 5; i++)
         exp_data[i] = IMM_DATA;
      exp_addr[5] = 16'h0350;
      exp_data[5] = IND_X_DATA;
      exp_addr[6] = IND_X_PTR;
      exp_data[6] = IND_Y_DATA;
      exp_addr[7] = IND_Y_BASE + {8'h00, Y_VAL};
      exp_data[7] = IND_Y_DATA;
      exp_addr[8] = DONE_ADDR;
      exp_data[8] = DONE_MARK;
   endtask

   //////////////////////////////////////////////////
   // checks at accepted transfers

   task automatic check_store(input m6502_bus_pkg::addr_t a, input m6502_bus_pkg::byte_t d);
      assert (a != SKIP_EQ && a != SKIP_NE)
      else
      begin
         $display("store to %h, which a taken branch should have skipped", a);
         errors++;
      end
      assert (store_idx < N_STORES)
      else
      begin
         $display("store to %h after all expected stores", a);
         errors++;
      end
      if (store_idx < N_STORES)
      begin
         assert (a == exp_addr[store_idx])
         else
         begin
            $display("ERROR addr: expected %h, got %h", exp_addr[store_idx], a);
            errors++;
         end
         assert (d == exp_data[store_idx])
         else
         begin
            $display("ERROR wr_data: expected %h, got %h", exp_data[store_idx], d);
            errors++;
         end
         store_idx++;
      end
      if (a == DONE_ADDR && d == DONE_MARK)
         done_seen = 1'b1;
   endtask

   task automatic check_read(input m6502_bus_pkg::addr_t a);
      if (target_due)
      begin
         assert (a == target_addr)
         else
         begin
            $display("ERROR addr: branch target expected %h, got %h", target_addr, a);
            errors++;
         end
         target_due = 1'b0;
      end
      if (a == BEQ_OFFSET_AT || a == BNE_OFFSET_AT)
      begin
         target_due  = 1'b1;
         target_addr = a + 16'd1 + {{8{mem[a][7]}}, mem[a]};   // both branches are taken.
      end
   endtask

   // the memory model serves one access at a time with 0 to 2 wait cycles.
   always @(negedge clk)
   begin
      if (rd_req || wr_en)
      begin
         if (!in_access)
         begin
            in_access  = 1'b1;
            waits_left = $unsigned($random(seed)) % 3;
         end
         if (waits_left > 0)
         begin
            waits_left = waits_left - 1;
            ready <= 1'b0;
         end
         else
         begin
            in_access = 1'b0;
            ready <= 1'b1;
            if (wr_en)
            begin
               check_store(addr, wr_data);
               mem[addr] = wr_data;
            end
            else
            begin
               rd_data <= mem[addr];
               check_read(addr);
            end
         end
      end
      else
         ready <= 1'b0;
   end

   initial
   begin
      clk        = 1'b0;
      reset_n    = 1'b0;
      rd_data    = '0;
      ready      = 1'b0;
      seed       = 32'h502468ad;
      waits_left = 0;
      store_idx  = 0;
      errors     = 0;
      in_access  = 1'b0;
      target_due = 1'b0;
      done_seen  = 1'b0;
      load_memory();
      fill_expected();
      repeat (3) @(negedge clk);
      reset_n = 1'b1;

      cycles = 0;
      while (!done_seen && cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycles++;
      end
      assert (done_seen)
      else
      begin
         $display("program did not reach its final store");
         errors++;
      end

      $display("errors: %0d, assertion failures: %0d", errors,
               u_m6502_cpu.u_cpu_assert.fail_count);
      if (errors == 0 && u_m6502_cpu.u_cpu_assert.fail_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
